/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the vector load testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert -j 0 \
    --top-module tb_xadac_vload \
    -f sim.f \
    -o vload_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/vload_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -Fqx '** PASS **' "$log"; then
    exit 0
fi
echo "Pass message not found in $log"
exit 1

/* sim.f */
src/xadac_pkg.sv
src/xadac_ex_if.sv
src/obi_if.sv
src/xadac_vload_unit.sv
src/obi_sram.sv
src/xadac_vload_top.sv
tb/tb_xadac_vload.sv

/* src/obi_if.sv */
`default_nettype none

interface obi_if
    import xadac_pkg::*;
();

    // A phase
    logic    req;
    logic    gnt;
    addr_t   addr;
    id_t     aid;

    // R phase
    logic    rvalid;
    logic    rready;
    id_t     rid;
    vector_t rdata;

    modport Master (
        output req, addr, aid, rready,
        input  gnt, rvalid, rid, rdata
    );

    modport Slave (
        input  req, addr, aid, rready,
        output gnt, rvalid, rid, rdata
    );

endinterface

`default_nettype wire

/* src/obi_sram.sv */
`default_nettype none

module obi_sram
    import xadac_pkg::*;
#(
    parameter int unsigned mem_words    = 16,
    parameter int unsigned read_latency = 1
) (
    input  logic    clk,
    input  logic    rstn,

    obi_if.Slave    bus,

    // Fill port, single-cycle strobe
    input  logic    we,
    input  addr_t   waddr,
    input  vector_t wdata
);

    localparam int unsigned idx_width = (mem_words > 1) ? $clog2(mem_words) : 1;

    typedef logic [idx_width-1:0] idx_t;

    vector_t                  mem [mem_words];

    logic                     grant;
    logic  [read_latency-1:0] pipe_valid;
    id_t                      pipe_id   [read_latency];
    vector_t                  pipe_data [read_latency];

    // Word index from the address bits above the vector offset
    function automatic idx_t word_index(addr_t a);
        return idx_t'((a >> 4) % mem_words);
    endfunction

    // A write strobe takes the array for the cycle
    assign grant   = bus.req && !we;
    assign bus.gnt = grant;

    always_ff @(posedge clk) begin
        if (we) begin
            mem[word_index(waddr)] <= wdata;
        end
    end

    // Read pipeline, stage 0 samples the array at the grant
    always_ff @(posedge clk) begin
        if (grant) begin
            pipe_id[0]   <= bus.aid;
            pipe_data[0] <= mem[word_index(bus.addr)];
        end
        for (int k = 1; k < read_latency; k++) begin
            pipe_id[k]   <= pipe_id[k-1];
            pipe_data[k] <= pipe_data[k-1];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pipe_valid <= '0;
        end else begin
            pipe_valid[0] <= grant;
            for (int k = 1; k < read_latency; k++) begin
                pipe_valid[k] <= pipe_valid[k-1];
            end
        end
    end

    assign bus.rvalid = pipe_valid[read_latency-1];
    assign bus.rid    = pipe_id[read_latency-1];
    assign bus.rdata  = pipe_data[read_latency-1];

    // The pipeline cannot stall, so the master must always accept
    a_rready: assert property (
        @(posedge clk) disable iff (!rstn)
        bus.rvalid |-> bus.rready
    );

endmodule

`default_nettype wire

/* src/xadac_ex_if.sv */
`default_nettype none

interface xadac_ex_if
    import xadac_pkg::*;
();

    // Request channel
    logic    req_valid;
    logic    req_ready;
    id_t     req_id;
    addr_t   req_rs1;
    imm_t    req_imm;

    // Response channel
    logic    resp_valid;
    logic    resp_ready;
    id_t     resp_id;
    vector_t resp_vd;

    // Execute stage side
    modport Master (
        output req_valid, req_id, req_rs1, req_imm, resp_ready,
        input  req_ready, resp_valid, resp_id, resp_vd
    );

    // Load unit side
    modport Slave (
        input  req_valid, req_id, req_rs1, req_imm, resp_ready,
        output req_ready, resp_valid, resp_id, resp_vd
    );

endinterface

`default_nettype wire

/* src/xadac_pkg.sv */
`default_nettype none

package xadac_pkg;

    // Field widths of the vector load channel
    localparam int unsigned id_width     = 2;
    localparam int unsigned addr_width   = 32;
    localparam int unsigned imm_width    = 3;
    localparam int unsigned elem_width   = 32;
    localparam int unsigned vector_width = 128;

    // Elements per vector
    localparam int unsigned num_elems = vector_width / elem_width;

    // Tag shared by a request, its bus read and its response
    typedef logic [id_width-1:0] id_t;

    // Byte address, the low four bits are ignored for aligned vectors
    typedef logic [addr_width-1:0] addr_t;

    // Repeat count, 0 passes the vector through and values above 4 act as 4
    typedef logic [imm_width-1:0] imm_t;

    typedef logic [elem_width-1:0] elem_t;

    // Element 0 sits in the low bits
    typedef logic [vector_width-1:0] vector_t;

endpackage

`default_nettype wire

/* src/xadac_vload_top.sv */
`default_nettype none

module xadac_vload_top
    import xadac_pkg::*;
#(
    parameter int unsigned mem_words    = 16,
    parameter int unsigned read_latency = 1
) (
    input  logic    clk,
    input  logic    rstn,

    // Load requests
    input  logic    req_valid,
    output logic    req_ready,
    input  id_t     req_id,
    input  addr_t   req_addr,
    input  imm_t    req_imm,

    // Vector responses
    output logic    resp_valid,
    input  logic    resp_ready,
    output id_t     resp_id,
    output vector_t resp_vd,

    // SRAM fill port
    input  logic    mem_we,
    input  addr_t   mem_waddr,
    input  vector_t mem_wdata
);

    xadac_ex_if ex_bus ();
    obi_if      obi_bus ();

    // Execute side of the request/response channel
    assign ex_bus.req_valid  = req_valid;
    assign ex_bus.req_id     = req_id;
    assign ex_bus.req_rs1    = req_addr;
    assign ex_bus.req_imm    = req_imm;
    assign ex_bus.resp_ready = resp_ready;

    assign req_ready  = ex_bus.req_ready;
    assign resp_valid = ex_bus.resp_valid;
    assign resp_id    = ex_bus.resp_id;
    assign resp_vd    = ex_bus.resp_vd;

    xadac_vload_unit i_xadac_vload_unit (
        .clk  (clk),
        .rstn (rstn),
        .slv  (ex_bus),
        .obi  (obi_bus)
    );

    obi_sram #(
        .mem_words    (mem_words),
        .read_latency (read_latency)
    ) i_obi_sram (
        .clk   (clk),
        .rstn  (rstn),
        .bus   (obi_bus),
        .we    (mem_we),
        .waddr (mem_waddr),
        .wdata (mem_wdata)
    );

endmodule

`default_nettype wire

/* src/xadac_vload_unit.sv */
`default_nettype none

module xadac_vload_unit
    import xadac_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,

    xadac_ex_if.Slave slv,
    obi_if.Master     obi
);

    localparam int unsigned num_entries = 2 ** id_width;

    // Per-entry progress flags are cleared when the response transfers
    typedef struct packed {
        logic requested;
        logic issued;
        logic returned;
    } flags_t;

    typedef struct packed {
        addr_t   addr;
        imm_t    imm;
        vector_t rdata;
    } payload_t;

    flags_t   [num_entries-1:0] flags_d, flags_q;
    payload_t [num_entries-1:0] data_d, data_q;

    logic    req_ready_c;
    logic    issue_found;
    logic    resp_found;

    logic    obi_req_d;
    addr_t   obi_addr_d;
    id_t     obi_aid_d;

    logic    resp_valid_d;
    id_t     resp_id_d;
    vector_t resp_vd_d;

    // Lane i takes element (i mod imm)
    // An imm of 0 or above num_elems keeps the vector
    function automatic vector_t replicate(vector_t v, imm_t imm);
        vector_t     res;
        elem_t       lane;
        int unsigned span;
        span = (imm == '0 || imm > imm_t'(num_elems)) ? num_elems : int'(imm);
        for (int unsigned i = 0; i < num_elems; i++) begin
            lane = v[(i % span) * elem_width +: elem_width];
            res[i * elem_width +: elem_width] = lane;
        end
        return res;
    endfunction

    assign obi.rready    = 1'b1;
    assign slv.req_ready = req_ready_c;

    always_comb begin
        flags_d      = flags_q;
        data_d       = data_q;

        obi_req_d    = obi.req;
        obi_addr_d   = obi.addr;
        obi_aid_d    = obi.aid;

        resp_valid_d = slv.resp_valid;
        resp_id_d    = slv.resp_id;
        resp_vd_d    = slv.resp_vd;

        issue_found  = 1'b0;
        resp_found   = 1'b0;

        // Read data returned
        if (obi.rvalid && obi.rready) begin
            data_d[obi.rid].rdata     = obi.rdata;
            flags_d[obi.rid].returned = 1'b1;
        end

        // Address granted
        if (obi.req && obi.gnt) begin
            flags_d[obi.aid].issued = 1'b1;
            obi_req_d               = 1'b0;
        end

        // The ID is free again in the cycle its response is taken
        if (slv.resp_valid && slv.resp_ready) begin
            flags_d[slv.resp_id] = '0;
            resp_valid_d         = 1'b0;
        end

        // Accept a new request on a free ID
        req_ready_c = slv.req_valid && !flags_d[slv.req_id].requested;
        if (req_ready_c) begin
            data_d[slv.req_id].addr        = slv.req_rs1;
            data_d[slv.req_id].imm         = slv.req_imm;
            flags_d[slv.req_id].requested  = 1'b1;
        end

        // Highest pending ID goes to the bus first
        if (!obi_req_d) begin
            for (int i = num_entries - 1; i >= 0; i--) begin
                if (!issue_found && flags_d[i].requested && !flags_d[i].issued) begin
                    issue_found = 1'b1;
                    obi_req_d   = 1'b1;
                    obi_addr_d  = data_d[i].addr;
                    obi_aid_d   = id_t'(i);
                end
            end
        end

        // Highest finished ID is answered first
        if (!resp_valid_d) begin
            for (int i = num_entries - 1; i >= 0; i--) begin
                if (!resp_found && flags_d[i].returned) begin
                    resp_found   = 1'b1;
                    resp_valid_d = 1'b1;
                    resp_id_d    = id_t'(i);
                    resp_vd_d    = replicate(data_d[i].rdata, data_d[i].imm);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            flags_q        <= '0;
            obi.req        <= 1'b0;
            slv.resp_valid <= 1'b0;
        end else begin
            flags_q        <= flags_d;
            obi.req        <= obi_req_d;
            slv.resp_valid <= resp_valid_d;
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        data_q      <= data_d;
        obi.addr    <= obi_addr_d;
        obi.aid     <= obi_aid_d;
        slv.resp_id <= resp_id_d;
        slv.resp_vd <= resp_vd_d;
    end

    // A stalled response keeps its vector
    a_resp_stable: assert property (
        @(posedge clk) disable iff (!rstn)
        slv.resp_valid && !slv.resp_ready |=> $stable(slv.resp_vd)
    );

    // Returned data belongs to an address the SRAM granted
    a_rid_issued: assert property (
        @(posedge clk) disable iff (!rstn)
        obi.rvalid |-> flags_q[obi.rid].issued
    );

    // Bus reads only go out for accepted requests
    a_req_requested: assert property (
        @(posedge clk) disable iff (!rstn)
        obi.req |-> flags_q[obi.aid].requested
    );

endmodule

`default_nettype wire

/* tb/tb_xadac_vload.sv */
`default_nettype none

module tb_xadac_vload
    import xadac_pkg::*;
();

    localparam int unsigned num_ids = 2 ** id_width;

    logic    clk = 1'b0;
    logic    rstn;
    logic    req_valid;
    logic    req_ready;
    id_t     req_id;
    addr_t   req_addr;
    imm_t    req_imm;
    logic    resp_valid;
    logic    resp_ready;
    id_t     resp_id;
    vector_t resp_vd;
    logic    mem_we;
    addr_t   mem_waddr;
    vector_t mem_wdata;

    // Expected vector per ID and how many loads each ID has seen accepted and answered
    vector_t exp_tbl [num_ids];
    int      accepted_cnt [num_ids];
    int      done_cnt [num_ids];

    int      err_value;
    int      err_other;
    int      cycle;
    int      cycle_limit;
    int      bp_len;
    int      bp_seq;

    xadac_vload_top i_xadac_vload_top (
        .clk        (clk),
        .rstn       (rstn),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_id     (req_id),
        .req_addr   (req_addr),
        .req_imm    (req_imm),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_id    (resp_id),
        .resp_vd    (resp_vd),
        .mem_we     (mem_we),
        .mem_waddr  (mem_waddr),
        .mem_wdata  (mem_wdata)
    );

    always #5 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic int pending_count();
        int n;
        n = 0;
        for (int i = 0; i < num_ids; i++) begin
            n += accepted_cnt[i] - done_cnt[i];
        end
        return n;
    endfunction

    task automatic check_vector(input string name, input vector_t got, input vector_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h at cycle %0d", name, got, exp, cycle);
            err_value++;
        end
    endtask

    task automatic check_id(input string name, input id_t got, input id_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h at cycle %0d", name, got, exp, cycle);
            err_value++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h at cycle %0d", name, got, exp, cycle);
            err_value++;
        end
    endtask

    task automatic report_counts();
        $display("Errors: %0d value mismatches, %0d other failures", err_value, err_other);
    endtask

    task automatic write_word(input addr_t a, input vector_t v);
        mem_we    = 1'b1;
        mem_waddr = a;
        mem_wdata = v;
        @(posedge clk);
        #1;
        mem_we    = 1'b0;
    endtask

    // Request is held until accepted
    // The expected value is recorded one edge after the transfer
    task automatic load_vector(input id_t id, input addr_t a, input imm_t imm,
                               input vector_t exp);
        req_valid = 1'b1;
        req_id    = id;
        req_addr  = a;
        req_imm   = imm;
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        exp_tbl[id] = exp;
        accepted_cnt[id]++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic stall_responses(input int n);
        bp_len = n;
        bp_seq++;
    endtask

    task automatic drain_responses();
        while (pending_count() != 0) @(posedge clk);
        // Leave room for a stray duplicate response
        repeat (10) @(posedge clk);
    endtask

    // resp_ready is low in B windows and on random LFSR bits
    initial begin : ready_driver
        logic [15:0] lfsr;
        int          hold_left;
        int          seen_seq;
        lfsr       = 16'd62036;
        hold_left  = 0;
        seen_seq   = 0;
        resp_ready = 1'b0;
        forever begin
            @(posedge clk);
            if (bp_seq != seen_seq) begin
                seen_seq  = bp_seq;
                hold_left = bp_len;
            end
            #1;
            if (hold_left > 0) begin
                resp_ready = 1'b0;
                hold_left--;
            end else begin
                lfsr       = lfsr_step(lfsr);
                resp_ready = lfsr[0];
            end
        end
    end

    initial begin : response_monitor
        logic    held;
        id_t     held_id;
        vector_t held_vd;
        held = 1'b0;
        forever begin
            @(negedge clk);
            if (!rstn) begin
                held = 1'b0;
            end else begin
                if (held && !resp_valid) begin
                    $display("ERROR: resp_valid dropped while stalled at cycle %0d", cycle);
                    err_other++;
                end else if (held) begin
                    check_id("resp_id", resp_id, held_id);
                    check_vector("resp_vd", resp_vd, held_vd);
                end
                held    = resp_valid && !resp_ready;
                held_id = resp_id;
                held_vd = resp_vd;
                if (resp_valid && resp_ready) begin
                    if (accepted_cnt[resp_id] == done_cnt[resp_id]) begin
                        $display("ERROR: response on ID %0d with no load outstanding at cycle %0d",
                                 resp_id, cycle);
                        err_other++;
                    end else begin
                        check_vector("resp_vd", resp_vd, exp_tbl[resp_id]);
                        done_cnt[resp_id]++;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        while (cycle_limit == 0 || cycle < cycle_limit) begin
            @(posedge clk);
            cycle++;
        end
        $display("ERROR: timeout at cycle %0d with %0d responses outstanding",
                 cycle, pending_count());
        err_other++;
        report_counts();
        $display("** FAIL **");
        $finish;
    end

    initial begin : main
        int                 fd;
        int                 code;
        int                 lines;
        int                 count;
        logic               seen_end;
        logic [7:0]         cmd;
        logic [8*160-1:0]   line_buf;
        id_t                id;
        addr_t              addr;
        imm_t               imm;
        vector_t            vec;
        rstn      = 1'b0;
        req_valid = 1'b0;
        req_id    = '0;
        req_addr  = '0;
        req_imm   = '0;
        mem_we    = 1'b0;
        mem_waddr = '0;
        mem_wdata = '0;
        lines     = 0;
        seen_end  = 1'b0;

        // Count records first to size the timeout
        fd = $fopen("tb/vload_stimulus.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open tb/vload_stimulus.txt");
            err_other++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line_buf, fd);
                if (code > 0) lines++;
            end
            $fclose(fd);
            cycle_limit = 40 * lines + 200;
            fd = $fopen("tb/vload_stimulus.txt", "r");
        end

        repeat (16) begin
            @(negedge clk);
            check_bit("resp_valid", resp_valid, 1'b0);
            check_bit("req_ready", req_ready, 1'b0);
        end
        @(posedge clk);
        #1;
        rstn = 1'b1;
        @(negedge clk);
        check_bit("resp_valid", resp_valid, 1'b0);
        check_bit("req_ready", req_ready, 1'b0);
        @(posedge clk);
        #1;

        while (fd != 0 && !seen_end) begin
            code = $fscanf(fd, " %c", cmd);
            if (code != 1) begin
                $display("ERROR: stimulus file ended without an end record");
                err_other++;
                seen_end = 1'b1;
            end else begin
                case (cmd)
                    "#": code = $fgets(line_buf, fd);
                    "W": begin
                        code = $fscanf(fd, "%h %h", addr, vec);
                        write_word(addr, vec);
                    end
                    "L": begin
                        code = $fscanf(fd, "%h %h %h %h", id, addr, imm, vec);
                        load_vector(id, addr, imm, vec);
                    end
                    "S": begin
                        code = $fscanf(fd, "%d", count);
                        idle_cycles(count);
                    end
                    "B": begin
                        code = $fscanf(fd, "%d", count);
                        stall_responses(count);
                    end
                    "E": seen_end = 1'b1;
                    default: begin
                        $display("ERROR: unknown stimulus record '%c'", cmd);
                        err_other++;
                        seen_end = 1'b1;
                    end
                endcase
            end
        end
        if (fd != 0) $fclose(fd);

        drain_responses();
        report_counts();
        if (err_value == 0 && err_other == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/vload_stimulus.txt */
# W addr vector | L id addr imm expected_vector | S idle_cycles | B stall_cycles | E
# Addresses, ids, imm and vectors in hex with element 0 rightmost, cycle counts in decimal
# Fill the SRAM
W 00000000 0a0000030a0000020a0000010a000000
W 00000010 0b0000030b0000020b0000010b000000
W 00000020 0c0000030c0000020c0000010c000000
W 00000030 0d0000030d0000020d0000010d000000
W 00000040 0e0000030e0000020e0000010e000000
W 000000f0 10000003100000021000000110000000
# Single loads, low address bits ignored and word index wraps
L 0 00000000 4 0a0000030a0000020a0000010a000000
S 8
L 1 0000001c 0 0b0000030b0000020b0000010b000000
L 2 000001f0 4 10000003100000021000000110000000
S 8
# Write strobe while a read waits for its grant
L 3 00000030 4 0d0000030d0000020d0000010d000000
W 00000050 0f0000030f0000020f0000010f000000
L 0 00000050 4 0f0000030f0000020f0000010f000000
S 10
W 00000000 1a0000031a0000021a0000011a000000
L 1 00000000 4 1a0000031a0000021a0000011a000000
S 8
# Replication
L 0 00000010 1 0b0000000b0000000b0000000b000000
L 1 00000010 2 0b0000010b0000000b0000010b000000
L 2 00000010 3 0b0000000b0000020b0000010b000000
L 3 00000010 7 0b0000030b0000020b0000010b000000
S 10
L 0 00000020 5 0c0000030c0000020c0000010c000000
L 1 00000040 2 0e0000010e0000000e0000010e000000
S 10
# Four loads in flight
L 0 00000010 4 0b0000030b0000020b0000010b000000
L 1 00000020 4 0c0000030c0000020c0000010c000000
L 2 00000030 4 0d0000030d0000020d0000010d000000
L 3 00000040 4 0e0000030e0000020e0000010e000000
S 16
# Busy ID
L 2 00000050 3 0f0000000f0000020f0000010f000000
L 2 00000000 4 1a0000031a0000021a0000011a000000
S 12
# Response back-pressure
B 12
L 0 00000030 1 0d0000000d0000000d0000000d000000
L 1 000000f0 2 10000001100000001000000110000000
L 2 00000040 4 0e0000030e0000020e0000010e000000
L 3 00000050 0 0f0000030f0000020f0000010f000000
S 6
B 20
L 0 00000020 2 0c0000010c0000000c0000010c000000
L 1 00000010 3 0b0000000b0000020b0000010b000000
E
